//--- sources.f
+incdir+include
hdl/fmc150_capture_pkg.sv
hdl/frame_stream_if.sv
hdl/capture_gate.sv
hdl/frame_builder.sv
hdl/stream_fifo.sv
hdl/fmc150_capture_top.sv
sim/capture_props.sv
sim/tb_fmc150_capture.sv

//--- run_sim.sh
#!/bin/sh
# build and run the capture testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing -Wno-fatal -j 0 \
  -f sources.f --top-module tb_fmc150_capture -o sim_tb

# the log decides the result, so a stopped run is still inspected
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
  exit 1
fi
if ! grep -qF '*** TEST PASSED ***' sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

//--- sim/tb_fmc150_capture.sv
`timescale 1ns/100ps
`include "capture_defs.svh"

// random capture bursts, output stream checked against a model of the framing rules
module tb_fmc150_capture;

  localparam int NUM_BURSTS  = 30;
  localparam int DDS_LATENCY = 2;
  localparam int FIFO_DEPTH  = 8;  // small, so the fifo fills and stamps get parked

  logic                             clk_245_76MHz;
  logic                             cpu_reset;
  fmc150_capture_pkg::iq_sample_t   adc_iq;
  fmc150_capture_pkg::iq_sample_t   dac_iq;
  logic                             sample_valid;
  logic                             adc_enable;
  logic                             chirp_init;
  logic [7:0]                       control_word;
  logic                             axis_tready;
  fmc150_capture_pkg::stream_word_t axis_tdata;
  logic                             axis_tvalid;
  logic                             axis_tlast;

  // model state
  fmc150_capture_pkg::stream_word_t offered_q[$];  // {adc, dac} of every valid cycle
  logic [7:0] ctrl_q[$];  // control word of each started burst
  logic [7:0] ctrl_now = 8'h00;
  int burst_len [NUM_BURSTS];
  int gap_len [NUM_BURSTS];
  int watchdog_cycles = 0;
  int trailer_count = 0;
  logic burst_started = 1'b0;
  logic in_frame = 1'b0;
  logic have_stamp = 1'b0;
  fmc150_capture_pkg::route_sel_t frame_upper;
  fmc150_capture_pkg::route_sel_t frame_lower;
  logic [fmc150_capture_pkg::COUNT_WIDTH-1:0] hdr_upper;
  logic [fmc150_capture_pkg::COUNT_WIDTH-1:0] hdr_lower;
  logic [fmc150_capture_pkg::COUNT_WIDTH-1:0] n_samples;
  logic [fmc150_capture_pkg::COUNT_WIDTH-1:0] last_cycle;  // newest cycle stamp seen in frame
  logic [fmc150_capture_pkg::COUNT_WIDTH-1:0] prev_stamp_upper;
  logic [fmc150_capture_pkg::COUNT_WIDTH-1:0] prev_trailer_lower = '0;  // counter starts at 0

  fmc150_capture_top #(
    .DDS_LATENCY (DDS_LATENCY),
    .FIFO_DEPTH  (FIFO_DEPTH)
  ) i_dut (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .adc_iq        (adc_iq),
    .dac_iq        (dac_iq),
    .sample_valid  (sample_valid),
    .adc_enable    (adc_enable),
    .chirp_init    (chirp_init),
    .control_word  (control_word),
    .axis_tready   (axis_tready),
    .axis_tdata    (axis_tdata),
    .axis_tvalid   (axis_tvalid),
    .axis_tlast    (axis_tlast)
  );

  initial begin
    clk_245_76MHz = 1'b0;
    forever #50 clk_245_76MHz = ~clk_245_76MHz;  // 100 ns period
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input fmc150_capture_pkg::stream_word_t act,
                            input fmc150_capture_pkg::stream_word_t exp);
    if (act !== exp)
      fail_run($sformatf("FAILED %s: got %h expected %h", name, act, exp));
  endtask

  task automatic check_last(input string name, input logic act, input logic exp);
    if (act !== exp)
      fail_run($sformatf("FAILED %s: got %h expected %h", name, act, exp));
  endtask

  task automatic check_count(input string name,
                             input logic [fmc150_capture_pkg::COUNT_WIDTH-1:0] act,
                             input logic [fmc150_capture_pkg::COUNT_WIDTH-1:0] exp);
    if (act !== exp)
      fail_run($sformatf("FAILED %s: got %h expected %h", name, act, exp));
  endtask

  // stamps carry the cycle counter, so each must be later than the one before
  task automatic check_stamp_order(input logic [31:0] stamp_cycle);
    if (have_stamp && !(stamp_cycle > prev_stamp_upper))
      fail_run("stamp word cycle count did not increase over the previous stamp");
    prev_stamp_upper = stamp_cycle;
    have_stamp = 1'b1;
  endtask

  // value one half should carry under its route
  function automatic logic [31:0] expected_half(
    input fmc150_capture_pkg::route_sel_t   sel,
    input fmc150_capture_pkg::stream_word_t pair,  // upper adc, lower dac
    input logic [31:0]                      count,
    input logic [31:0]                      cyc
  );
    case (sel)
      fmc150_capture_pkg::route_adc_iq:       return pair.upper;
      fmc150_capture_pkg::route_dac_iq:       return pair.lower;
      fmc150_capture_pkg::route_sample_count: return count;
      default:                                return cyc;
    endcase
  endfunction

  // one clock of random stimulus
  task automatic drive_cycle(input logic en, input logic chirp_ok);
    logic                           sv;
    fmc150_capture_pkg::iq_sample_t a;
    fmc150_capture_pkg::iq_sample_t d;
    sv = ($urandom % 4) != 0;  // about 75%
    a  = $urandom;
    d  = $urandom;
    @(posedge clk_245_76MHz);
    adc_enable   <= en;
    sample_valid <= sv;
    adc_iq       <= a;
    dac_iq       <= d;
    axis_tready  <= ($urandom % 5) != 0;  // low about 20%
    chirp_init   <= chirp_ok && (($urandom % 16) == 0);
    control_word <= ctrl_now;
    if (sv)
      offered_q.push_back({a, d});
  endtask

  // model of one accepted output word
  task automatic take_word(input fmc150_capture_pkg::stream_word_t word, input logic last);
    fmc150_capture_pkg::stream_word_t pair;
    fmc150_capture_pkg::stream_word_t exp;
    logic [7:0]  ctrl;
    logic        iq_up;
    logic        iq_lo;
    logic        found;
    logic [31:0] cyc;
    pair = '0;
    cyc  = word.upper;
    if (!in_frame) begin  // header
      check_last("axis_tlast", last, 1'b0);
      if (ctrl_q.size() == 0)
        fail_run("header word arrived with no burst started");
      ctrl        = ctrl_q.pop_front();
      frame_upper = fmc150_capture_pkg::route_sel_t'(ctrl[`ROUTE_UPPER_LSB +: `ROUTE_WIDTH]);
      frame_lower = fmc150_capture_pkg::route_sel_t'(ctrl[`ROUTE_LOWER_LSB +: `ROUTE_WIDTH]);
      check_count("axis_tdata.lower", word.lower, prev_trailer_lower);
      check_stamp_order(word.upper);
      hdr_upper  = word.upper;
      hdr_lower  = word.lower;
      last_cycle = word.upper;
      n_samples  = '0;
      in_frame   = 1'b1;
    end else if (last) begin  // trailer
      check_count("axis_tdata.lower", word.lower, hdr_lower + n_samples);
      check_stamp_order(word.upper);
      if ((word.upper - hdr_upper) < n_samples)
        fail_run("trailer cycle count is too close to the header for the samples in the frame");
      prev_trailer_lower = word.lower;
      in_frame = 1'b0;
      trailer_count++;
    end else begin  // sample
      iq_up = (frame_upper == fmc150_capture_pkg::route_adc_iq) ||
              (frame_upper == fmc150_capture_pkg::route_dac_iq);
      iq_lo = (frame_lower == fmc150_capture_pkg::route_adc_iq) ||
              (frame_lower == fmc150_capture_pkg::route_dac_iq);
      if (frame_lower == fmc150_capture_pkg::route_cycle_count)
        cyc = word.lower;
      if (frame_upper == fmc150_capture_pkg::route_cycle_count ||
          frame_lower == fmc150_capture_pkg::route_cycle_count) begin
        if (!(cyc > last_cycle))
          fail_run("cycle count in a sample word did not advance");
        last_cycle = cyc;
      end
      if (iq_up || iq_lo) begin
        found = 1'b0;
        while (!found && offered_q.size() > 0) begin  // skipped entries were dropped
          pair  = offered_q.pop_front();
          found = (!iq_up || word.upper == expected_half(frame_upper, pair, 0, 0)) &&
                  (!iq_lo || word.lower == expected_half(frame_lower, pair, 0, 0));
        end
        if (!found)
          fail_run("sample word matches no offered ADC or DAC sample in order");
      end
      exp.upper = expected_half(frame_upper, pair, hdr_lower + n_samples, cyc);
      exp.lower = expected_half(frame_lower, pair, hdr_lower + n_samples, cyc);
      check_word("axis_tdata", word, exp);
      n_samples = n_samples + 1;
    end
  endtask

  // stream sampled mid-cycle, where tready and the DUT outputs are settled
  always @(negedge clk_245_76MHz) begin
    if (!cpu_reset) begin
      if (axis_tvalid && !burst_started)
        fail_run("axis_tvalid went high before the first burst");
      if (axis_tvalid && axis_tready)
        take_word(axis_tdata, axis_tlast);
    end
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk_245_76MHz);
    fail_run("watchdog expired before all bursts came out of the stream");
  end

  initial begin
    int total;
    void'($urandom(32'hec5ef516));
    cpu_reset    <= 1'b1;
    adc_iq       <= '0;
    dac_iq       <= '0;
    sample_valid <= 1'b0;
    adc_enable   <= 1'b0;
    chirp_init   <= 1'b0;
    control_word <= 8'h00;
    axis_tready  <= 1'b0;
    total = 20;
    for (int b = 0; b < NUM_BURSTS; b++) begin
      burst_len[b] = 12 + int'($urandom % 48);
      gap_len[b]   = 10 + int'($urandom % 16);  // long enough for the trailer to form
      total += burst_len[b] + gap_len[b];
    end
    watchdog_cycles = total * 4 + 1000;
    repeat (5) @(posedge clk_245_76MHz);
    cpu_reset <= 1'b0;
    repeat (20) drive_cycle(1'b0, 1'b0);  // quiet stream after reset
    for (int b = 0; b < NUM_BURSTS; b++) begin
      ctrl_now = 8'($urandom);  // unused control bits stay random
      if (b % 2 == 0) begin
        ctrl_now[`ROUTE_UPPER_LSB +: `ROUTE_WIDTH] = fmc150_capture_pkg::route_adc_iq;
        ctrl_now[`ROUTE_LOWER_LSB +: `ROUTE_WIDTH] = fmc150_capture_pkg::route_dac_iq;
      end
      ctrl_q.push_back(ctrl_now);
      burst_started = 1'b1;
      // no chirp near the end, the burst must open before the enable drops
      for (int c = 0; c < burst_len[b]; c++)
        drive_cycle(1'b1, (burst_len[b] - c) > 8);
      for (int c = 0; c < gap_len[b]; c++)
        drive_cycle(1'b0, 1'b0);
    end
    while (trailer_count < NUM_BURSTS)
      drive_cycle(1'b0, 1'b0);
    repeat (8) drive_cycle(1'b0, 1'b0);  // room for a stray word to show up
    @(negedge clk_245_76MHz);
    if (axis_tvalid) begin
      fail_run("stream still carried words after the last trailer");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- sim/capture_props.sv
`timescale 1ns/100ps

// handshake and burst pulse rules, bound into the capture top level
module capture_props (
  input logic                             clk_245_76MHz,
  input logic                             cpu_reset,
  input fmc150_capture_pkg::stream_word_t axis_tdata,
  input logic                             axis_tvalid,
  input logic                             axis_tlast,
  input logic                             axis_tready,
  input logic                             frame_first,
  input logic                             frame_last
);

  logic burst_open;  // header pulse seen, trailer pulse not yet

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset)
      burst_open <= 1'b0;
    else if (frame_first)
      burst_open <= 1'b1;
    else if (frame_last)
      burst_open <= 1'b0;
  end

  // stalled word stays on the bus unchanged
  a_stream_hold: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    axis_tvalid && !axis_tready |=>
      axis_tvalid && $stable(axis_tdata) && $stable(axis_tlast))
    else $error("stream word changed or vanished while axis_tready was low");

  // header and trailer never share a cycle
  a_pulse_apart: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    !(frame_first && frame_last))
    else $error("frame_first and frame_last high together");

  // new header only once the previous burst was closed by its trailer
  a_first_from_idle: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    frame_first |-> !burst_open)
    else $error("frame_first fired while a burst was already open");

endmodule

bind fmc150_capture_top capture_props i_capture_props (
  .clk_245_76MHz (clk_245_76MHz),
  .cpu_reset     (cpu_reset),
  .axis_tdata    (axis_tdata),
  .axis_tvalid   (axis_tvalid),
  .axis_tlast    (axis_tlast),
  .axis_tready   (axis_tready),
  .frame_first   (frame_first),
  .frame_last    (frame_last)
);

//--- hdl/fmc150_capture_top.sv
`timescale 1ns/100ps
`include "capture_defs.svh"

// ADC capture path: gate, frame builder and output fifo
module fmc150_capture_top #(
  parameter int DDS_LATENCY = 2,   // settle cycles after enable drop or chirp
  parameter int FIFO_DEPTH  = 64
) (
  input  logic                             clk_245_76MHz,
  input  logic                             cpu_reset,
  input  fmc150_capture_pkg::iq_sample_t   adc_iq,
  input  fmc150_capture_pkg::iq_sample_t   dac_iq,
  input  logic                             sample_valid,
  input  logic                             adc_enable,
  input  logic                             chirp_init,
  input  logic [7:0]                       control_word,  // route fields
  input  logic                             axis_tready,
  output fmc150_capture_pkg::stream_word_t axis_tdata,
  output logic                             axis_tvalid,
  output logic                             axis_tlast
);

  fmc150_capture_pkg::route_sel_t route_upper;
  fmc150_capture_pkg::route_sel_t route_lower;
  logic capture_on;
  logic frame_first;
  logic frame_last;

  frame_stream_if frame_bus ();

  // split control_word into the two half selects
  assign route_upper = fmc150_capture_pkg::route_sel_t'(
                         control_word[`ROUTE_UPPER_LSB +: `ROUTE_WIDTH]);
  assign route_lower = fmc150_capture_pkg::route_sel_t'(
                         control_word[`ROUTE_LOWER_LSB +: `ROUTE_WIDTH]);

  capture_gate #(
    .DDS_LATENCY (DDS_LATENCY)
  ) i_capture_gate (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .adc_enable    (adc_enable),
    .chirp_init    (chirp_init),
    .capture_on    (capture_on),
    .frame_first   (frame_first),
    .frame_last    (frame_last)
  );

  frame_builder i_frame_builder (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .adc_iq        (adc_iq),
    .dac_iq        (dac_iq),
    .sample_valid  (sample_valid),
    .route_upper   (route_upper),
    .route_lower   (route_lower),
    .capture_on    (capture_on),
    .frame_first   (frame_first),
    .frame_last    (frame_last),
    .frame_bus     (frame_bus.source)
  );

  stream_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_stream_fifo (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .frame_bus     (frame_bus.sink),
    .stream_tdata  (axis_tdata),
    .stream_tlast  (axis_tlast),
    .stream_tvalid (axis_tvalid),
    .stream_tready (axis_tready)
  );

endmodule

//--- hdl/stream_fifo.sv
`timescale 1ns/100ps

// synchronous fifo between frame_builder and the output stream
module stream_fifo #(
  parameter int FIFO_DEPTH = 64  // power of two
) (
  input  logic                             clk_245_76MHz,
  input  logic                             cpu_reset,
  frame_stream_if.sink                     frame_bus,
  output fmc150_capture_pkg::stream_word_t stream_tdata,
  output logic                             stream_tlast,
  output logic                             stream_tvalid,
  input  logic                             stream_tready
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  fmc150_capture_pkg::stream_word_t word_mem [FIFO_DEPTH];
  logic                             last_mem [FIFO_DEPTH];  // tlast beside each word

  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic [ADDR_WIDTH:0]   fill;  // occupancy, one bit wider to reach full
  logic                  push;
  logic                  pop;

  assign frame_bus.ready = (fill != (ADDR_WIDTH + 1)'(FIFO_DEPTH));  // low only when full
  assign stream_tvalid   = (fill != '0);

  assign push = frame_bus.valid & frame_bus.ready;
  assign pop  = stream_tvalid & stream_tready;

  // head of the queue read straight from the array
  // so a word written into an empty fifo shows on the next cycle
  assign stream_tdata = word_mem[rd_ptr];
  assign stream_tlast = last_mem[rd_ptr];

  always_ff @(posedge clk_245_76MHz) begin
    if (push) begin
      word_mem[wr_ptr] <= frame_bus.word;
      last_mem[wr_ptr] <= frame_bus.last;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;  // both or neither
      endcase
    end
  end

endmodule

//--- hdl/frame_builder.sv
`timescale 1ns/100ps

// forms header, sample and trailer words for the stream fifo
module frame_builder (
  input  logic                            clk_245_76MHz,
  input  logic                            cpu_reset,
  input  fmc150_capture_pkg::iq_sample_t  adc_iq,
  input  fmc150_capture_pkg::iq_sample_t  dac_iq,
  input  logic                            sample_valid,  // no ready toward the ADC
  input  fmc150_capture_pkg::route_sel_t  route_upper,
  input  fmc150_capture_pkg::route_sel_t  route_lower,
  input  logic                            capture_on,
  input  logic                            frame_first,
  input  logic                            frame_last,
  frame_stream_if.source                  frame_bus
);

  logic [fmc150_capture_pkg::COUNT_WIDTH-1:0] cycle_count;   // every clock since reset
  logic [fmc150_capture_pkg::COUNT_WIDTH-1:0] sample_count;  // accepted samples only

  fmc150_capture_pkg::stream_word_t stamp_word;
  fmc150_capture_pkg::stream_word_t sample_word;
  fmc150_capture_pkg::stream_word_t hold_word;  // refused stamp parked here

  logic hold_valid;
  logic hold_last;
  logic hold_load;
  logic stamp_req;
  logic sample_sel;
  logic accept;

  // picks one 32-bit half by its route select
  function automatic logic [31:0] route_pick(
    input fmc150_capture_pkg::route_sel_t sel,
    input fmc150_capture_pkg::iq_sample_t adc,
    input fmc150_capture_pkg::iq_sample_t dac,
    input logic [31:0]                    samples,
    input logic [31:0]                    cycles
  );
    case (sel)
      fmc150_capture_pkg::route_adc_iq:       return adc;
      fmc150_capture_pkg::route_dac_iq:       return dac;
      fmc150_capture_pkg::route_sample_count: return samples;
      default:                                return cycles;
    endcase
  endfunction

  assign stamp_req  = frame_first | frame_last;
  // stamps and a parked word win, samples in those cycles are dropped
  assign sample_sel = ~hold_valid & ~stamp_req & capture_on & sample_valid;

  assign stamp_word.upper  = cycle_count;
  assign stamp_word.lower  = sample_count;
  assign sample_word.upper = route_pick(route_upper, adc_iq, dac_iq, sample_count, cycle_count);
  assign sample_word.lower = route_pick(route_lower, adc_iq, dac_iq, sample_count, cycle_count);

  // word onto the bus in the same cycle it is formed
  always_comb begin
    if (hold_valid) begin
      frame_bus.word  = hold_word;
      frame_bus.last  = hold_last;
      frame_bus.valid = 1'b1;  // held until taken
    end else if (stamp_req) begin
      frame_bus.word  = stamp_word;
      frame_bus.last  = frame_last;  // trailer closes the frame
      frame_bus.valid = 1'b1;
    end else begin
      frame_bus.word  = sample_word;
      frame_bus.last  = 1'b0;
      frame_bus.valid = sample_sel;
    end
  end

  assign accept = frame_bus.valid & frame_bus.ready;

  // park a stamp that could not go out now
  // a parked word leaving frees the slot for a stamp in the same cycle
  assign hold_load = stamp_req & (hold_valid ? accept : ~frame_bus.ready);

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      cycle_count  <= '0;
      sample_count <= '0;
    end else begin
      cycle_count <= cycle_count + 1'b1;  // wraps freely
      if (accept && sample_sel)
        sample_count <= sample_count + 1'b1;  // refused samples not counted
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset)
      hold_valid <= 1'b0;
    else if (hold_load)
      hold_valid <= 1'b1;
    else if (accept)
      hold_valid <= 1'b0;
  end

  // payload of the parked stamp
  always_ff @(posedge clk_245_76MHz) begin
    if (hold_load) begin
      hold_word <= stamp_word;
      hold_last <= frame_last;
    end
  end

endmodule

//--- hdl/capture_gate.sv
`timescale 1ns/100ps

// opens and closes capture bursts once the DDS has settled
module capture_gate #(
  parameter int DDS_LATENCY = 2  // 1..15, fits the 4-bit settle counter
) (
  input  logic clk_245_76MHz,
  input  logic cpu_reset,
  input  logic adc_enable,
  input  logic chirp_init,
  output logic capture_on,   // level, burst open
  output logic frame_first,  // pulse, header slot
  output logic frame_last    // pulse, trailer slot
);

  logic       enable_q;    // adc_enable one cycle late
  logic [3:0] settle_cnt;  // DDS latency countdown
  logic       settled;

  assign settled = (settle_cnt == 4'd0);

  // enable register and capture level
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      enable_q   <= 1'b0;
      capture_on <= 1'b0;
    end else begin
      enable_q <= adc_enable;
      if (settled)
        capture_on <= enable_q;  // only follows once the counter is idle
    end
  end

  // settle counter
  // reloads on a new chirp or on the falling edge of the enable
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      settle_cnt <= 4'd0;
    end else if (chirp_init) begin
      settle_cnt <= 4'(DDS_LATENCY);
    end else if (enable_q && !adc_enable) begin
      settle_cnt <= 4'(DDS_LATENCY);  // enable just dropped
    end else if (!settled) begin
      settle_cnt <= settle_cnt - 4'd1;
    end
  end

  // header pulse lands in the same cycle capture_on rises
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset)
      frame_first <= 1'b0;
    else
      frame_first <= settled & enable_q & ~capture_on;
  end

  // trailer in the last cycle capture_on is still high
  // cannot meet frame_first, the counter is reloaded right after a drop
  assign frame_last = settled & capture_on & ~enable_q;

endmodule

//--- hdl/frame_stream_if.sv
`timescale 1ns/100ps

// framed words from frame_builder into stream_fifo
interface frame_stream_if;

  fmc150_capture_pkg::stream_word_t word;  // header, sample or trailer
  logic last;   // set on the trailer only
  logic valid;
  logic ready;  // low only while the fifo is full

  modport source (
    output word, last, valid,
    input  ready
  );

  modport sink (
    input  word, last, valid,
    output ready
  );

endinterface

//--- hdl/fmc150_capture_pkg.sv
package fmc150_capture_pkg;

  // width of the cycle and sample counters
  // must stay 32 so a count fills one half of a stream word
  parameter int COUNT_WIDTH = 32;

  // one ADC or DAC sample, i on top as in the FMC150 data path
  typedef struct packed {
    logic [15:0] i;  // in-phase
    logic [15:0] q;  // quadrature
  } iq_sample_t;

  // 64-bit word as it leaves on the stream
  // stamp words carry cycle count above, sample count below
  typedef struct packed {
    logic [31:0] upper;
    logic [31:0] lower;
  } stream_word_t;

  // what fills one half of a sample word
  typedef enum logic [1:0] {
    route_adc_iq       = 2'd0,  // raw ADC pair
    route_dac_iq       = 2'd1,  // DAC pair, loopback view
    route_sample_count = 2'd2,  // accepted-sample counter
    route_cycle_count  = 2'd3   // free-running clock counter
  } route_sel_t;

endpackage

//--- include/capture_defs.svh
`ifndef CAPTURE_DEFS_SVH
`define CAPTURE_DEFS_SVH

// route fields inside control_word, lower half select in the low nibble
`define ROUTE_LOWER_LSB 0
`define ROUTE_UPPER_LSB 4
`define ROUTE_WIDTH     2

`endif
